//--- common/tcp_rx_settings.svh
`ifndef TCP_RX_SETTINGS_SVH
`define TCP_RX_SETTINGS_SVH

// width of one noc flit.
`define TCP_RX_FLIT_W 64

// width of the remaining-flit counter.
`define TCP_RX_CNT_W 16

// smallest legal length field, the meta flit plus one data flit.
`define TCP_RX_MIN_LEN 2

`endif

//--- common/noc_pkg.sv
package noc_pkg;

    // node id on the noc.
    typedef logic [7:0] noc_node_t;

    // flits that follow the header, meta flit included.
    typedef logic [15:0] noc_len_t;

    typedef enum logic [7:0] {
        MSG_TCP_RX_DATA  = 8'h21,
        MSG_TCP_RX_PROBE = 8'h22
    } noc_msg_type_e;

    // header flit fields.
    localparam int NOC_DST_HI  = 63;
    localparam int NOC_DST_LO  = 56;

    localparam int NOC_SRC_HI  = 55;
    localparam int NOC_SRC_LO  = 48;

    localparam int NOC_TYPE_HI = 47;
    localparam int NOC_TYPE_LO = 40;

    // bits 39..16 are unused by this tile.
    localparam int NOC_LEN_HI  = 15;
    localparam int NOC_LEN_LO  = 0;

endpackage

//--- common/tcp_rx_pkg.sv
package tcp_rx_pkg;

    typedef logic [31:0] tcp_seq_t;
    typedef logic [15:0] tcp_port_t;

    // meta flit fields.
    localparam int TCP_SEQ_HI      = 63;
    localparam int TCP_SEQ_LO      = 32;

    localparam int TCP_SRC_PORT_HI = 31;
    localparam int TCP_SRC_PORT_LO = 16;

    localparam int TCP_DST_PORT_HI = 15;
    localparam int TCP_DST_PORT_LO = 0;

    // flit sequencing.
    typedef enum logic [1:0] {
        READY        = 2'd0,
        META_FLIT    = 2'd1,
        DATA_FLITS   = 2'd2,
        DATA_TX_WAIT = 2'd3
    } data_state_e;

    // header record issue.
    typedef enum logic [1:0] {
        WAITING         = 2'd0,
        META_OUTPUT     = 2'd1,
        META_OUTPUT_REG = 2'd2,
        META_TX_WAIT    = 2'd3
    } meta_state_e;

endpackage

//--- noc_in/tcp_rx_noc_in_ctrl.sv
`timescale 1ns/1ps

module tcp_rx_noc_in_ctrl (
     input                  clk
    ,input                  rst

    ,input                  in_val
    ,output logic           in_rdy

    ,output logic           hdr_val
    ,input                  hdr_rdy

    ,output logic           data_val
    ,input                  data_rdy

    ,output logic           store_hdr_flit
    ,output logic           store_meta_flit
    ,output logic           init_num_flits
    ,output logic           decr_num_flits

    ,input                  last_flit
);

    import tcp_rx_pkg::*;

    data_state_e data_state_reg;
    data_state_e data_state_next;

    meta_state_e meta_state_reg;
    meta_state_e meta_state_next;

    logic both_tx_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_state_reg <= READY;
            meta_state_reg <= WAITING;
        end
        else begin
            data_state_reg <= data_state_next;
            meta_state_reg <= meta_state_next;
        end
    end

    // flit sequencing.
    always_comb begin
        store_hdr_flit = 1'b0;
        store_meta_flit = 1'b0;
        init_num_flits = 1'b0;
        decr_num_flits = 1'b0;

        in_rdy = 1'b0;
        data_val = 1'b0;

        data_state_next = data_state_reg;

        case (data_state_reg)
            READY: begin
                in_rdy = 1'b1;

                if (in_val) begin
                    store_hdr_flit = 1'b1;
                    init_num_flits = 1'b1;

                    data_state_next = META_FLIT;
                end
            end
            META_FLIT: begin
                in_rdy = 1'b1;

                if (in_val) begin
                    store_meta_flit = 1'b1;
                    decr_num_flits = 1'b1;

                    data_state_next = DATA_FLITS;
                end
            end
            DATA_FLITS: begin
                // payload goes straight through, so the handshake does too.
                data_val = in_val;
                in_rdy = data_rdy;

                if (in_val & data_rdy) begin
                    decr_num_flits = 1'b1;

                    if (last_flit) begin
                        data_state_next = DATA_TX_WAIT;
                    end
                end
            end
            DATA_TX_WAIT: begin
                if (meta_state_reg == META_TX_WAIT) begin
                    data_state_next = READY;
                end
            end
            default: begin
                data_state_next = READY;
            end
        endcase
    end

    // header record issue, started by the header flit.
    always_comb begin
        hdr_val = 1'b0;

        meta_state_next = meta_state_reg;

        case (meta_state_reg)
            WAITING: begin
                if (data_state_next == META_FLIT) begin
                    meta_state_next = META_OUTPUT;
                end
            end
            META_OUTPUT: begin
                // record goes out with the live meta flit.
                if (in_val) begin
                    hdr_val = 1'b1;

                    if (hdr_rdy) begin
                        meta_state_next = META_TX_WAIT;
                    end
                    else begin
                        meta_state_next = META_OUTPUT_REG;
                    end
                end
            end
            META_OUTPUT_REG: begin
                if (hdr_rdy) begin
                    hdr_val = 1'b1;

                    meta_state_next = META_TX_WAIT;
                end
            end
            META_TX_WAIT: begin
                if (data_state_reg == DATA_TX_WAIT) begin
                    meta_state_next = WAITING;
                end
            end
            default: begin
                meta_state_next = WAITING;
            end
        endcase
    end

    assign both_tx_wait = (data_state_reg == DATA_TX_WAIT) &&
                          (meta_state_reg == META_TX_WAIT);

    // no record without a message in flight.
    a_no_hdr_when_waiting: assert property (
        @(posedge clk) disable iff (rst)
        hdr_val |-> (data_state_reg != READY)
    ) else $error("hdr_val asserted while no message is in flight");

    // the rendezvous releases both machines at once.
    a_rendezvous_one_cycle: assert property (
        @(posedge clk) disable iff (rst)
        both_tx_wait |=> !both_tx_wait
    ) else $error("data and header FSMs stuck in TX_WAIT");

endmodule

//--- noc_in/tcp_rx_noc_in_datap.sv
`timescale 1ns/1ps

`include "tcp_rx_settings.svh"

module tcp_rx_noc_in_datap (
     input                              clk
    ,input                              rst

    ,input          [`TCP_RX_FLIT_W-1:0] in_data

    ,input                              store_hdr_flit
    ,input                              store_meta_flit
    ,input                              init_num_flits
    ,input                              decr_num_flits

    ,output logic                       last_flit

    ,output logic   [`TCP_RX_FLIT_W-1:0] hdr_flit_reg
    ,output logic   [`TCP_RX_FLIT_W-1:0] meta_flit_reg

    ,output logic   [`TCP_RX_FLIT_W-1:0] data
    ,output logic                       data_last
);

    import noc_pkg::*;

    logic [`TCP_RX_CNT_W-1:0] num_flits_reg;
    logic [`TCP_RX_CNT_W-1:0] hdr_len;

    assign hdr_len = in_data[NOC_LEN_HI:NOC_LEN_LO];

    always_ff @(posedge clk) begin
        if (store_hdr_flit) begin
            hdr_flit_reg <= in_data;
        end
        if (store_meta_flit) begin
            meta_flit_reg <= in_data;
        end
    end

    // counts the meta flit and the payload flits still to come.
    always_ff @(posedge clk) begin
        if (rst) begin
            num_flits_reg <= '0;
        end
        else if (init_num_flits) begin
            num_flits_reg <= hdr_len;
        end
        else if (decr_num_flits) begin
            num_flits_reg <= num_flits_reg - 1'b1;
        end
    end

    assign last_flit = (num_flits_reg == `TCP_RX_CNT_W'd1);

    // payload passes through.
    assign data = in_data;
    assign data_last = last_flit;

    // a header must announce a meta flit and some payload.
    a_min_length: assert property (
        @(posedge clk) disable iff (rst)
        init_num_flits |-> (hdr_len >= `TCP_RX_MIN_LEN)
    ) else $error("header length %0d below minimum", hdr_len);

endmodule

//--- design/tcp_rx_hdr_decode.sv
`timescale 1ns/1ps

`include "tcp_rx_settings.svh"

module tcp_rx_hdr_decode (
     input          [`TCP_RX_FLIT_W-1:0] in_data
    ,input                              meta_live

    ,input          [`TCP_RX_FLIT_W-1:0] hdr_flit_reg
    ,input          [`TCP_RX_FLIT_W-1:0] meta_flit_reg

    ,output noc_pkg::noc_node_t         hdr_src
    ,output logic                       hdr_type_err
    ,output tcp_rx_pkg::tcp_seq_t       hdr_seq
    ,output tcp_rx_pkg::tcp_port_t      hdr_src_port
    ,output tcp_rx_pkg::tcp_port_t      hdr_dst_port
    ,output noc_pkg::noc_len_t          hdr_payload_flits
);

    import noc_pkg::*;
    import tcp_rx_pkg::*;

    logic [`TCP_RX_FLIT_W-1:0] meta_flit;
    noc_msg_type_e             msg_type;
    noc_len_t                  msg_len;

    // live flit while it is on the bus, the stored copy afterwards.
    assign meta_flit = meta_live ? in_data : meta_flit_reg;

    assign msg_type = noc_msg_type_e'(hdr_flit_reg[NOC_TYPE_HI:NOC_TYPE_LO]);
    assign msg_len = hdr_flit_reg[NOC_LEN_HI:NOC_LEN_LO];

    assign hdr_src = hdr_flit_reg[NOC_SRC_HI:NOC_SRC_LO];

    // probes and unknown opcodes are flagged for the consumer.
    assign hdr_type_err = (msg_type != MSG_TCP_RX_DATA);

    // length counts the meta flit too.
    assign hdr_payload_flits = msg_len - 16'd1;

    assign hdr_seq = meta_flit[TCP_SEQ_HI:TCP_SEQ_LO];
    assign hdr_src_port = meta_flit[TCP_SRC_PORT_HI:TCP_SRC_PORT_LO];
    assign hdr_dst_port = meta_flit[TCP_DST_PORT_HI:TCP_DST_PORT_LO];

endmodule

//--- design/tcp_rx_noc_in_top.sv
`timescale 1ns/1ps

`include "tcp_rx_settings.svh"

module tcp_rx_noc_in_top (
     input                              clk
    ,input                              rst

    ,input                              in_val
    ,output logic                       in_rdy
    ,input          [`TCP_RX_FLIT_W-1:0] in_data

    ,output logic                       hdr_val
    ,input                              hdr_rdy
    ,output noc_pkg::noc_node_t         hdr_src
    ,output logic                       hdr_type_err
    ,output tcp_rx_pkg::tcp_seq_t       hdr_seq
    ,output tcp_rx_pkg::tcp_port_t      hdr_src_port
    ,output tcp_rx_pkg::tcp_port_t      hdr_dst_port
    ,output noc_pkg::noc_len_t          hdr_payload_flits

    ,output logic                       data_val
    ,input                              data_rdy
    ,output logic   [`TCP_RX_FLIT_W-1:0] data
    ,output logic                       data_last
);

    logic                       store_hdr_flit;
    logic                       store_meta_flit;
    logic                       init_num_flits;
    logic                       decr_num_flits;
    logic                       last_flit;

    logic [`TCP_RX_FLIT_W-1:0]  hdr_flit_reg;
    logic [`TCP_RX_FLIT_W-1:0]  meta_flit_reg;

    tcp_rx_noc_in_ctrl i_tcp_rx_noc_in_ctrl (
         .clk               (clk)
        ,.rst               (rst)
        ,.in_val            (in_val)
        ,.in_rdy            (in_rdy)
        ,.hdr_val           (hdr_val)
        ,.hdr_rdy           (hdr_rdy)
        ,.data_val          (data_val)
        ,.data_rdy          (data_rdy)
        ,.store_hdr_flit    (store_hdr_flit)
        ,.store_meta_flit   (store_meta_flit)
        ,.init_num_flits    (init_num_flits)
        ,.decr_num_flits    (decr_num_flits)
        ,.last_flit         (last_flit)
    );

    tcp_rx_noc_in_datap i_tcp_rx_noc_in_datap (
         .clk               (clk)
        ,.rst               (rst)
        ,.in_data           (in_data)
        ,.store_hdr_flit    (store_hdr_flit)
        ,.store_meta_flit   (store_meta_flit)
        ,.init_num_flits    (init_num_flits)
        ,.decr_num_flits    (decr_num_flits)
        ,.last_flit         (last_flit)
        ,.hdr_flit_reg      (hdr_flit_reg)
        ,.meta_flit_reg     (meta_flit_reg)
        ,.data              (data)
        ,.data_last         (data_last)
    );

    // the meta store strobe marks the cycle the meta flit is live.
    tcp_rx_hdr_decode i_tcp_rx_hdr_decode (
         .in_data           (in_data)
        ,.meta_live         (store_meta_flit)
        ,.hdr_flit_reg      (hdr_flit_reg)
        ,.meta_flit_reg     (meta_flit_reg)
        ,.hdr_src           (hdr_src)
        ,.hdr_type_err      (hdr_type_err)
        ,.hdr_seq           (hdr_seq)
        ,.hdr_src_port      (hdr_src_port)
        ,.hdr_dst_port      (hdr_dst_port)
        ,.hdr_payload_flits (hdr_payload_flits)
    );

endmodule

//--- dv/tb_tcp_rx_noc_in.sv
`timescale 1ns/1ps

`include "tcp_rx_settings.svh"

module tb_tcp_rx_noc_in;

    import noc_pkg::*;
    import tcp_rx_pkg::*;

    localparam int MEM_DEPTH       = 256;
    localparam int CYCLES_PER_FLIT = 20;

    logic                       clk;
    logic                       rst;
    logic                       in_val;
    logic                       in_rdy;
    logic [`TCP_RX_FLIT_W-1:0]  in_data;
    logic                       hdr_val;
    logic                       hdr_rdy;
    noc_node_t                  hdr_src;
    logic                       hdr_type_err;
    tcp_seq_t                   hdr_seq;
    tcp_port_t                  hdr_src_port;
    tcp_port_t                  hdr_dst_port;
    noc_len_t                   hdr_payload_flits;
    logic                       data_val;
    logic                       data_rdy;
    logic [`TCP_RX_FLIT_W-1:0]  data;
    logic                       data_last;

    logic [63:0] stim_mem [0:MEM_DEPTH-1];

    // input flits of all messages, in order.
    logic [63:0] flits_q [$];
    int          msg_flits [$];
    logic [7:0]  gap_mode [$];
    logic [7:0]  hdr_mode [$];
    logic [7:0]  data_mode [$];

    logic [7:0]  exp_src [$];
    logic        exp_err [$];
    logic [31:0] exp_seq [$];
    logic [15:0] exp_sport [$];
    logic [15:0] exp_dport [$];
    logic [15:0] exp_pay [$];
    logic [63:0] exp_data [$];
    logic        exp_last [$];

    integer      seed;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          hdr_seen = 0;
    int          data_seen = 0;
    int          in_pos = 0;
    int          in_msg = 0;
    logic [7:0]  act_hdr_mode;
    logic [7:0]  act_data_mode;
    int          act_cyc;

    tcp_rx_noc_in_top i_tcp_rx_noc_in_top (
         .clk               (clk)
        ,.rst               (rst)
        ,.in_val            (in_val)
        ,.in_rdy            (in_rdy)
        ,.in_data           (in_data)
        ,.hdr_val           (hdr_val)
        ,.hdr_rdy           (hdr_rdy)
        ,.hdr_src           (hdr_src)
        ,.hdr_type_err      (hdr_type_err)
        ,.hdr_seq           (hdr_seq)
        ,.hdr_src_port      (hdr_src_port)
        ,.hdr_dst_port      (hdr_dst_port)
        ,.hdr_payload_flits (hdr_payload_flits)
        ,.data_val          (data_val)
        ,.data_rdy          (data_rdy)
        ,.data              (data)
        ,.data_last         (data_last)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5;
            clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at time %0d ns: %s expected %h, got %h",
                                $time, name, expected, actual));
        end
    endtask

    // 00 always ready, ff random, otherwise low for that many cycles.
    function automatic logic ready_at(input logic [7:0] mode, input int cyc);
        if (mode == 8'hff) begin
            return (($random(seed) & 32'd3) != 32'd0);
        end
        return cyc >= int'(mode);
    endfunction

    task automatic load_messages();
        int          ptr;
        int          i;
        logic [63:0] ctrl;
        logic [63:0] meta;
        logic [15:0] npay;
        ptr = 0;
        while (ptr < MEM_DEPTH - 1 && stim_mem[ptr][15:0] != 16'd0) begin
            ctrl = stim_mem[ptr];
            meta = stim_mem[ptr + 1];
            npay = ctrl[15:0];
            // length on the noc counts the meta flit as well.
            flits_q.push_back({ctrl[63:40], 24'h0, npay + 16'd1});
            flits_q.push_back(meta);
            msg_flits.push_back(int'(npay) + 2);
            gap_mode.push_back(ctrl[39:32]);
            hdr_mode.push_back(ctrl[31:24]);
            data_mode.push_back(ctrl[23:16]);
            exp_src.push_back(ctrl[55:48]);
            exp_err.push_back(ctrl[47:40] == MSG_TCP_RX_PROBE);
            exp_seq.push_back(meta[63:32]);
            exp_sport.push_back(meta[31:16]);
            exp_dport.push_back(meta[15:0]);
            exp_pay.push_back(npay);
            for (i = 0; i < int'(npay); i = i + 1) begin
                flits_q.push_back(stim_mem[ptr + 2 + i]);
                exp_data.push_back(stim_mem[ptr + 2 + i]);
                exp_last.push_back(i == int'(npay) - 1);
            end
            ptr = ptr + 2 + int'(npay);
        end
    endtask

    // output scoreboard and input-side protocol checks.
    always @(posedge clk) begin
        if (!rst) begin
            if (in_msg < msg_flits.size() && in_pos >= 2) begin
                check_value("in_rdy", 64'(data_rdy), 64'(in_rdy));
                check_value("data_val", 64'(in_val), 64'(data_val));
            end
            if (in_val && in_rdy && in_msg < msg_flits.size()) begin
                if (in_pos == 0) begin
                    check_value("hdr_seen", 64'(in_msg), 64'(hdr_seen));
                end
                in_pos = in_pos + 1;
                if (in_pos == msg_flits[in_msg]) begin
                    in_pos = 0;
                    in_msg = in_msg + 1;
                end
            end
            if (hdr_val && hdr_rdy) begin
                if (hdr_seen >= msg_flits.size()) begin
                    abort_run("a header record left the DUT with no message outstanding");
                end
                check_value("hdr_src", 64'(exp_src[hdr_seen]), 64'(hdr_src));
                check_value("hdr_type_err", 64'(exp_err[hdr_seen]), 64'(hdr_type_err));
                check_value("hdr_seq", 64'(exp_seq[hdr_seen]), 64'(hdr_seq));
                check_value("hdr_src_port", 64'(exp_sport[hdr_seen]), 64'(hdr_src_port));
                check_value("hdr_dst_port", 64'(exp_dport[hdr_seen]), 64'(hdr_dst_port));
                check_value("hdr_payload_flits", 64'(exp_pay[hdr_seen]),
                            64'(hdr_payload_flits));
                hdr_seen <= hdr_seen + 1;
            end
            if (data_val && data_rdy) begin
                if (data_seen >= exp_data.size()) begin
                    abort_run("a data flit left the DUT after all payload was delivered");
                end
                check_value("data", exp_data[data_seen], data);
                check_value("data_last", 64'(exp_last[data_seen]), 64'(data_last));
                data_seen <= data_seen + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, outputs still missing",
                                cycle_count));
        end
    end

    initial begin
        int   m;
        int   fi;
        int   flit_idx;
        int   idle;
        logic offering;
        logic took;
        seed = 32'h290a_c2e8;
        rst = 1'b1;
        in_val = 1'b0;
        in_data = '0;
        hdr_rdy = 1'b0;
        data_rdy = 1'b0;
        act_hdr_mode = 8'h00;
        act_data_mode = 8'h00;
        act_cyc = 0;
        $readmemh("dv/tcp_rx_noc_in_input.txt", stim_mem);
        load_messages();
        if (msg_flits.size() == 0) begin
            abort_run("the stimulus file holds no messages");
        end
        cycle_limit = flits_q.size() * CYCLES_PER_FLIT;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        @(posedge clk);
        check_value("in_rdy", 64'(1'b1), 64'(in_rdy));
        check_value("hdr_val", 64'(1'b0), 64'(hdr_val));
        check_value("data_val", 64'(1'b0), 64'(data_val));
        #1;

        flit_idx = 0;
        for (m = 0; m < msg_flits.size(); m = m + 1) begin
            idle = (gap_mode[m] == 8'hff) ? 0 : int'(gap_mode[m]);
            offering = 1'b0;
            fi = 0;
            while (fi < msg_flits[m]) begin
                if (!offering) begin
                    if (idle > 0) begin
                        idle = idle - 1;
                    end
                    else if (gap_mode[m] != 8'hff || ($random(seed) & 32'd1) != 32'd0) begin
                        offering = 1'b1;
                    end
                end
                in_val = offering;
                in_data = offering ? flits_q[flit_idx] : '0;
                hdr_rdy = ready_at(act_hdr_mode, act_cyc);
                data_rdy = ready_at(act_data_mode, act_cyc);
                @(posedge clk);
                took = in_val && in_rdy;
                #1;
                act_cyc = act_cyc + 1;
                if (took) begin
                    // stall patterns count from the accepted header.
                    if (fi == 0) begin
                        act_hdr_mode = hdr_mode[m];
                        act_data_mode = data_mode[m];
                        act_cyc = 0;
                    end
                    fi = fi + 1;
                    flit_idx = flit_idx + 1;
                    offering = 1'b0;
                end
            end
        end

        in_val = 1'b0;
        in_data = '0;
        while (hdr_seen < msg_flits.size() || data_seen < exp_data.size()) begin
            hdr_rdy = ready_at(act_hdr_mode, act_cyc);
            data_rdy = ready_at(act_data_mode, act_cyc);
            @(posedge clk);
            #1;
            act_cyc = act_cyc + 1;
        end
        hdr_rdy = 1'b1;
        data_rdy = 1'b1;

        // back in READY after the last rendezvous.
        repeat (3) @(posedge clk);
        check_value("in_rdy", 64'(1'b1), 64'(in_rdy));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- dv/tcp_rx_noc_in_input.txt
// control word: dst src type in_val_gap hdr_rdy data_rdy payload_count, then the meta flit
// modes: 00 none, ff random, n idle or held low n cycles; payload flits follow
0110210000000003 1a2b3c4d1f900050
1111111100000001 2222222200000002 3333333300000003
021122ff00ff0005 000000011388c350
a5a5a5a5a5a5a5a5 5a5a5a5a5a5a5a5a 0123456789abcdef fedcba9876543210 8000000000000001
// header held back across the meta flit.
0312210009000002 deadbeef04d20bb8
0f0f0f0f0f0f0f0f f0f0f0f0f0f0f0f0
041321ffffff0004 7fffffff00160017
0000000000000000 ffffffffffffffff 00000000ffffffff c0ffee00c0ffee00
// short probe whose header is still pending when the next message arrives.
051422000c000001 0000100001bb01bb
1234567812345678
0615210200050003 8badf00d270f0015
6666666600000006 7777777700000007 8888888800000008
// end of messages.
0000000000000000

//--- list.f
+incdir+common
common/noc_pkg.sv
common/tcp_rx_pkg.sv
noc_in/tcp_rx_noc_in_ctrl.sv
noc_in/tcp_rx_noc_in_datap.sv
design/tcp_rx_hdr_decode.sv
design/tcp_rx_noc_in_top.sv
dv/tb_tcp_rx_noc_in.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_tcp_rx_noc_in -f list.f -o sim_tb

status=0
output=$(./obj_dir/sim_tb 2>&1) || status=$?
echo "$output"

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
